//--- hsk_stream_pkg.sv
package hsk_stream_pkg;

    // one 64-bit beat of the udp payload stream, byte 0 of the packet in the low byte
    typedef logic [63:0] qword_t;

    // byte enables of one beat where bit n qualifies byte n
    typedef logic [7:0] keep_t;

    // number of qwords in one stored packet, so 511 at most
    typedef logic [8:0] qword_count_t;

    // occupancy of the payload fifo, which has to reach a full 512
    typedef logic [9:0] fill_count_t;

    // length field of the udp header, which counts the 8 header bytes as well
    typedef logic [15:0] udp_length_t;

    // the 8 extra header bytes in the length make dropping the low 3 bits
    // a safe upward round to whole qwords
    localparam int LENGTH_SHIFT = 3;

    // largest packet that a count entry can describe
    localparam int MAX_QWORDS = (1 << $bits(qword_count_t)) - 1;

endpackage

//--- hsk_serial_pkg.sv
package hsk_serial_pkg;

    // one byte as it goes out on miso
    typedef logic [7:0] byte_t;

    // bit position inside the byte being shifted out
    typedef logic [2:0] bit_index_t;

    // which byte of the head qword is loaded next
    typedef logic [2:0] byte_index_t;

    // bytes loaded so far for the packet being read
    // 511 qwords of 8 bytes still fits in 12 bits
    typedef logic [11:0] read_count_t;

endpackage

//--- hsk_fifo.sv
`timescale 1ns/100ps

module hsk_fifo
    import hsk_stream_pkg::*;
#(
    parameter type entry_t = qword_t,
    parameter int  DEPTH   = 512
) (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        wr_en,
    input  entry_t      wr_data,
    output logic        full,
    output fill_count_t fill,
    input  logic        rd_en,
    output entry_t      rd_data,
    output logic        valid
);

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int LAST_SLOT = DEPTH - 1;

    entry_t               mem [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    fill_count_t          count;
    logic                 do_write;
    logic                 do_read;

    // a write into a full fifo or a pop from an empty one is ignored
    assign do_write = wr_en && !full;
    assign do_read  = rd_en && valid;

    // storage array, written in place and read straight from the head
    always_ff @(posedge aclk) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap by hand so that depths other than a power of two work
            if (do_write) begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(LAST_SLOT)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(LAST_SLOT)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // first word fall through with the head entry already on rd_data
    assign rd_data = mem[rd_ptr];
    assign valid   = (count != '0);
    assign full    = (count == fill_count_t'(DEPTH));
    assign fill    = count;

endmodule

//--- udp_rx_writer.sv
`timescale 1ns/100ps

module udp_rx_writer
    import hsk_stream_pkg::*;
#(
    parameter int PAYLOAD_DEPTH = 512
) (
    input  logic         aclk,
    input  logic         aresetn,
    input  qword_t       s_udphdr_tdata,
    input  logic         s_udphdr_tvalid,
    output logic         s_udphdr_tready,
    input  qword_t       s_udpdata_tdata,
    input  keep_t        s_udpdata_tkeep,
    input  logic         s_udpdata_tlast,
    input  logic         s_udpdata_tvalid,
    output logic         s_udpdata_tready,
    input  logic         payload_full,
    input  fill_count_t  payload_fill,
    output logic         payload_wr,
    output qword_t       payload_data,
    input  logic         count_full,
    output logic         count_wr,
    output qword_count_t count_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STORE,
        ST_COMPLETE,
        ST_DUMP
    } state_t;

    state_t       state;
    udp_length_t  hdr_length;
    udp_length_t  hdr_qwords;
    udp_length_t  free_qwords;
    logic         hdr_taken;
    logic         data_taken;
    logic         drop_packet;
    qword_count_t beat_count;

    //////////////////////////////////////////////////////////////////////
    // admission check on the header
    //////////////////////////////////////////////////////////////////////

    // length sits in the low 16 bits of the header beat
    assign hdr_length = s_udphdr_tdata[$bits(udp_length_t)-1:0];
    assign hdr_qwords = hdr_length >> LENGTH_SHIFT;

    // fill never exceeds the depth so this cannot go negative
    assign free_qwords = udp_length_t'(PAYLOAD_DEPTH) - udp_length_t'(payload_fill);

    // dump anything the count fifo cannot describe, anything that will not fit,
    // and anything arriving while there is no slot left for its count
    assign drop_packet = (hdr_qwords > udp_length_t'(MAX_QWORDS)) ||
                         (hdr_qwords > free_qwords) ||
                         count_full;

    assign hdr_taken  = s_udphdr_tvalid && s_udphdr_tready;
    assign data_taken = s_udpdata_tvalid && s_udpdata_tready;

    //////////////////////////////////////////////////////////////////////
    // store and dump
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr_taken) begin
                        state <= drop_packet ? ST_DUMP : ST_STORE;
                    end
                end
                ST_STORE: begin
                    if (data_taken && s_udpdata_tlast) begin
                        state <= ST_COMPLETE;
                    end
                end
                // one cycle to push the count
                ST_COMPLETE: state <= ST_IDLE;
                ST_DUMP: begin
                    if (data_taken && s_udpdata_tlast) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // in dump every beat is swallowed, in store only while the fifo has room
    assign s_udphdr_tready  = (state == ST_IDLE);
    assign s_udpdata_tready = (state == ST_DUMP) || ((state == ST_STORE) && !payload_full);

    // bytes without their keep bit go into the fifo as zero
    always_comb begin
        for (int i = 0; i < $bits(keep_t); i++) begin
            payload_data[8*i +: 8] = s_udpdata_tdata[8*i +: 8] & {8{s_udpdata_tkeep[i]}};
        end
    end

    assign payload_wr = data_taken && (state == ST_STORE);

    // the count pushed is the beats actually stored and not the header figure
    always_ff @(posedge aclk) begin
        if (!aresetn || state == ST_IDLE) begin
            beat_count <= '0;
        end else if (payload_wr) begin
            beat_count <= beat_count + 1'b1;
        end
    end

    assign count_wr   = (state == ST_COMPLETE);
    assign count_data = beat_count;

endmodule

//--- hsk_serial_reader.sv
`timescale 1ns/100ps

module hsk_serial_reader
    import hsk_stream_pkg::*;
    import hsk_serial_pkg::*;
(
    input  logic         aclk,
    input  logic         aresetn,
    input  logic         sclk,
    input  logic         cs_b,
    output logic         miso,
    input  qword_t       payload_data,
    input  logic         payload_valid,
    output logic         payload_rd,
    input  qword_count_t count_data,
    input  logic         count_valid,
    output logic         count_rd,
    output logic         irq_o,
    output logic         complete_o
);

    // a qword holds 8 bytes so a count turns into bytes with a shift by 3
    localparam int QWORD_BYTE_SHIFT = $clog2($bits(qword_t) / $bits(byte_t));

    logic        sclk_meta;
    logic        sclk_sync;
    logic        sclk_prev;
    logic        cs_meta;
    logic        cs_sync;
    logic        cs_prev;
    logic        sclk_rise;
    logic        cs_fall;
    logic        reading;
    byte_t       shift_reg;
    byte_t       head_byte;
    bit_index_t  bit_cnt;
    byte_index_t byte_sel;
    read_count_t read_cnt;
    read_count_t packet_bytes;
    logic        start_packet;
    logic        last_bit;
    logic        end_packet;
    logic        load_byte;
    logic        count_popped;

    //////////////////////////////////////////////////////////////////////
    // synchronizers and edge detection
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            sclk_meta <= 1'b0;
            sclk_sync <= 1'b0;
            sclk_prev <= 1'b0;
            cs_meta   <= 1'b1;
            cs_sync   <= 1'b1;
            cs_prev   <= 1'b1;
        end else begin
            sclk_meta <= sclk;
            sclk_sync <= sclk_meta;
            sclk_prev <= sclk_sync;
            cs_meta   <= cs_b;
            cs_sync   <= cs_meta;
            cs_prev   <= cs_sync;
        end
    end

    // clock edges only count while the master holds chip select low
    assign sclk_rise = sclk_sync && !sclk_prev && !cs_sync;
    assign cs_fall   = !cs_sync && cs_prev;

    //////////////////////////////////////////////////////////////////////
    // byte selection and shift out
    //////////////////////////////////////////////////////////////////////

    assign packet_bytes = read_count_t'(count_data) << QWORD_BYTE_SHIFT;
    // lowest byte of the head qword goes first since that is arrival order
    assign head_byte    = payload_data[byte_sel*$bits(byte_t) +: $bits(byte_t)];

    // a packet already in flight carries on through a cs_b toggle
    assign start_packet = cs_fall && !reading && count_valid;
    // the rise that shifts past bit 0 finishes the current byte
    assign last_bit     = sclk_rise && reading && (bit_cnt == '1);
    assign end_packet   = last_bit && (read_cnt == packet_bytes);
    assign load_byte    = start_packet || (last_bit && !end_packet);

    // the head qword is done once its eighth byte sits in the shift register
    assign payload_rd = load_byte && (byte_sel == '1) && payload_valid;
    assign count_rd   = end_packet && count_valid;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            reading   <= 1'b0;
            shift_reg <= '0;
            bit_cnt   <= '0;
            byte_sel  <= '0;
            read_cnt  <= '0;
        end else begin
            if (start_packet) begin
                reading <= 1'b1;
            end else if (end_packet) begin
                reading <= 1'b0;
            end

            if (load_byte) begin
                shift_reg <= head_byte;
                bit_cnt   <= '0;
                byte_sel  <= byte_sel + 1'b1;
                read_cnt  <= read_cnt + 1'b1;
            end else if (end_packet) begin
                // clear everything so miso idles low and the next packet starts at byte 0
                shift_reg <= '0;
                bit_cnt   <= '0;
                byte_sel  <= '0;
                read_cnt  <= '0;
            end else if (sclk_rise && reading) begin
                shift_reg <= shift_reg << 1;
                bit_cnt   <= bit_cnt + 1'b1;
            end
        end
    end

    // msb first, changing after each rise so the master can sample on the fall
    assign miso = shift_reg[$bits(byte_t)-1];

    //////////////////////////////////////////////////////////////////////
    // status flags
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            count_popped <= 1'b0;
            irq_o        <= 1'b0;
            complete_o   <= 1'b0;
        end else begin
            // valid lags the pop by a cycle so the clear is held off by one
            count_popped <= count_rd;
            if (count_popped) begin
                irq_o <= 1'b0;
            end else if (count_valid) begin
                irq_o <= 1'b1;
            end

            if (cs_fall) begin
                complete_o <= 1'b0;
            end else if (count_rd) begin
                complete_o <= 1'b1;
            end
        end
    end

endmodule

//--- hsk_read_top.sv
`timescale 1ns/100ps

module hsk_read_top
    import hsk_stream_pkg::*;
#(
    parameter int PAYLOAD_DEPTH = 512,
    parameter int COUNT_DEPTH   = 4
) (
    input  logic   aclk,
    input  logic   aresetn,
    input  qword_t s_udphdr_tdata,
    input  logic   s_udphdr_tvalid,
    output logic   s_udphdr_tready,
    input  qword_t s_udpdata_tdata,
    input  keep_t  s_udpdata_tkeep,
    input  logic   s_udpdata_tlast,
    input  logic   s_udpdata_tvalid,
    output logic   s_udpdata_tready,
    input  logic   sclk,
    input  logic   cs_b,
    output logic   miso,
    output logic   irq_o,
    output logic   complete_o
);

    // writer side of the two fifos
    logic         payload_wr;
    qword_t       payload_wr_data;
    logic         payload_full;
    fill_count_t  payload_fill;
    logic         count_wr;
    qword_count_t count_wr_data;
    logic         count_full;

    // reader side of the two fifos
    qword_t       payload_head;
    logic         payload_valid;
    logic         payload_rd;
    qword_count_t count_head;
    logic         count_valid;
    logic         count_rd;

    udp_rx_writer #(
        .PAYLOAD_DEPTH(PAYLOAD_DEPTH)
    ) u_writer (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .s_udphdr_tdata  (s_udphdr_tdata),
        .s_udphdr_tvalid (s_udphdr_tvalid),
        .s_udphdr_tready (s_udphdr_tready),
        .s_udpdata_tdata (s_udpdata_tdata),
        .s_udpdata_tkeep (s_udpdata_tkeep),
        .s_udpdata_tlast (s_udpdata_tlast),
        .s_udpdata_tvalid(s_udpdata_tvalid),
        .s_udpdata_tready(s_udpdata_tready),
        .payload_full    (payload_full),
        .payload_fill    (payload_fill),
        .payload_wr      (payload_wr),
        .payload_data    (payload_wr_data),
        .count_full      (count_full),
        .count_wr        (count_wr),
        .count_data      (count_wr_data)
    );

    hsk_fifo #(
        .entry_t(qword_t),
        .DEPTH  (PAYLOAD_DEPTH)
    ) u_payload_fifo (
        .aclk   (aclk),
        .aresetn(aresetn),
        .wr_en  (payload_wr),
        .wr_data(payload_wr_data),
        .full   (payload_full),
        .fill   (payload_fill),
        .rd_en  (payload_rd),
        .rd_data(payload_head),
        .valid  (payload_valid)
    );

    // the fill level of the count fifo has no user, only its full flag matters
    hsk_fifo #(
        .entry_t(qword_count_t),
        .DEPTH  (COUNT_DEPTH)
    ) u_count_fifo (
        .aclk   (aclk),
        .aresetn(aresetn),
        .wr_en  (count_wr),
        .wr_data(count_wr_data),
        .full   (count_full),
        .fill   (),
        .rd_en  (count_rd),
        .rd_data(count_head),
        .valid  (count_valid)
    );

    hsk_serial_reader u_reader (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .sclk         (sclk),
        .cs_b         (cs_b),
        .miso         (miso),
        .payload_data (payload_head),
        .payload_valid(payload_valid),
        .payload_rd   (payload_rd),
        .count_data   (count_head),
        .count_valid  (count_valid),
        .count_rd     (count_rd),
        .irq_o        (irq_o),
        .complete_o   (complete_o)
    );

endmodule

//--- hsk_read_tb.sv
`timescale 1ns/100ps

module hsk_read_tb
    import hsk_stream_pkg::*;
    import hsk_serial_pkg::*;
();

    // long enough for an oversize packet to drain beat by beat
    localparam int TIMEOUT_CYCLES = 4000;
    // aclk cycles per sclk phase
    localparam int PHASE_CYCLES   = 4;

    logic   aclk;
    logic   aresetn;
    qword_t s_udphdr_tdata;
    logic   s_udphdr_tvalid;
    logic   s_udphdr_tready;
    qword_t s_udpdata_tdata;
    keep_t  s_udpdata_tkeep;
    logic   s_udpdata_tlast;
    logic   s_udpdata_tvalid;
    logic   s_udpdata_tready;
    logic   sclk;
    logic   cs_b;
    logic   miso;
    logic   irq_o;
    logic   complete_o;

    integer seed;
    string  test_name;
    int     test_errors;
    int     total_errors;
    int     tests_run;
    int     tests_failed;
    logic   complete_exp;
    // bytes still to come out of the port, with the tkeep holes already zeroed
    byte_t  exp_bytes[$];
    // readout length in bytes of every packet still queued in the DUT
    int     exp_lengths[$];

    hsk_read_top #(
        .PAYLOAD_DEPTH(512),
        .COUNT_DEPTH  (4)
    ) u_dut (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .s_udphdr_tdata  (s_udphdr_tdata),
        .s_udphdr_tvalid (s_udphdr_tvalid),
        .s_udphdr_tready (s_udphdr_tready),
        .s_udpdata_tdata (s_udpdata_tdata),
        .s_udpdata_tkeep (s_udpdata_tkeep),
        .s_udpdata_tlast (s_udpdata_tlast),
        .s_udpdata_tvalid(s_udpdata_tvalid),
        .s_udpdata_tready(s_udpdata_tready),
        .sclk            (sclk),
        .cs_b            (cs_b),
        .miso            (miso),
        .irq_o           (irq_o),
        .complete_o      (complete_o)
    );

    always #5 aclk = ~aclk;

    task automatic log_mismatch(input string what, input logic [63:0] exp,
                                input logic [63:0] act);
        $display("FAILED %s: %s expected %0h actual %0h", test_name, what, exp, act);
        test_errors++;
    endtask

    task automatic flag_error(input string what);
        $display("ERROR in %s: %s", test_name, what);
        test_errors++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // stream driver
    //////////////////////////////////////////////////////////////////////

    // ready is looked at on the falling aclk edge where it has settled,
    // and the beat is taken on the rising edge after it
    task automatic offer_header(input int length);
        bit taken;
        int t;
        taken           = 1'b0;
        s_udphdr_tdata  = qword_t'(length);
        s_udphdr_tvalid = 1'b1;
        for (t = 0; t < TIMEOUT_CYCLES && !taken; t++) begin
            @(negedge aclk);
            taken = s_udphdr_tready;
            @(posedge aclk);
            #1;
        end
        s_udphdr_tvalid = 1'b0;
        assert (taken) else flag_error("header beat was never accepted");
    endtask

    task automatic offer_beat(input qword_t data, input keep_t keep, input bit last);
        bit taken;
        int t;
        taken            = 1'b0;
        s_udpdata_tdata  = data;
        s_udpdata_tkeep  = keep;
        s_udpdata_tlast  = last;
        s_udpdata_tvalid = 1'b1;
        for (t = 0; t < TIMEOUT_CYCLES && !taken; t++) begin
            @(negedge aclk);
            taken = s_udpdata_tready;
            @(posedge aclk);
            #1;
        end
        s_udpdata_tvalid = 1'b0;
        s_udpdata_tlast  = 1'b0;
        assert (taken) else flag_error("data beat was never accepted");
    endtask

    // the bytes past the end of the payload carry random junk with keep low,
    // so the DUT has to zero them itself
    task automatic send_packet(input int nbytes, input bit admit);
        int     beats;
        int     b;
        int     i;
        qword_t data;
        keep_t  keep;
        beats = (nbytes + 7) / 8;
        offer_header(nbytes + 8);
        for (b = 0; b < beats; b++) begin
            data = {$random(seed), $random(seed)};
            for (i = 0; i < 8; i++) begin
                keep[i] = (b * 8 + i < nbytes);
                if (admit) begin
                    exp_bytes.push_back(keep[i] ? data[8*i +: 8] : 8'h00);
                end
            end
            offer_beat(data, keep, b == beats - 1);
        end
        if (admit) begin
            exp_lengths.push_back(beats * 8);
        end
    endtask

    task automatic wait_flag(input bit use_irq, input string what);
        bit seen;
        int t;
        seen = 1'b0;
        for (t = 0; t < TIMEOUT_CYCLES && !seen; t++) begin
            @(negedge aclk);
            seen = use_irq ? irq_o : complete_o;
        end
        @(posedge aclk);
        #1;
        assert (seen) else flag_error({what, " never rose"});
    endtask

    //////////////////////////////////////////////////////////////////////
    // serial master
    //////////////////////////////////////////////////////////////////////

    // sclk idles high, each bit is sampled as the master pulls sclk low
    // and the following rise moves the DUT on to the next bit
    task automatic read_packet();
        int    nbytes;
        bit    has_data;
        int    i;
        int    k;
        byte_t got;
        byte_t exp;
        has_data = (exp_lengths.size() != 0);
        nbytes   = 8;
        if (has_data) begin
            nbytes = exp_lengths.pop_front();
        end
        // complete_o from the previous read is still held at this point
        assert (complete_o === complete_exp)
            else log_mismatch("complete_o before cs_b fall", 64'(complete_exp), 64'(complete_o));
        cs_b = 1'b0;
        repeat (2 * PHASE_CYCLES) @(posedge aclk);
        #1;
        assert (complete_o === 1'b0)
            else log_mismatch("complete_o after cs_b fall", 64'(0), 64'(complete_o));
        for (i = 0; i < nbytes; i++) begin
            got = '0;
            for (k = 0; k < 8; k++) begin
                sclk = 1'b0;
                got  = {got[6:0], miso};
                repeat (PHASE_CYCLES) @(posedge aclk);
                #1;
                sclk = 1'b1;
                repeat (PHASE_CYCLES) @(posedge aclk);
                #1;
            end
            exp = 8'h00;
            if (has_data && exp_bytes.size() != 0) begin
                exp = exp_bytes.pop_front();
            end
            assert (got === exp) else log_mismatch($sformatf("byte %0d", i), 64'(exp), 64'(got));
        end
        if (has_data) begin
            wait_flag(1'b0, "complete_o");
            // irq drops a cycle after the pop and comes back if more is queued
            repeat (3) @(posedge aclk);
            #1;
            assert (irq_o === (exp_lengths.size() != 0))
                else log_mismatch("irq_o after read", 64'(exp_lengths.size() != 0), 64'(irq_o));
        end else begin
            repeat (2 * PHASE_CYCLES) @(posedge aclk);
            #1;
            assert (complete_o === 1'b0)
                else log_mismatch("complete_o after empty read", 64'(0), 64'(complete_o));
        end
        complete_exp = has_data;
        cs_b = 1'b1;
        repeat (2 * PHASE_CYCLES) @(posedge aclk);
        #1;
    endtask

    task automatic close_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d checks failed", test_name, test_errors);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int    fd;
        int    nbytes;
        int    admit;
        int    reads;
        string line;
        string name;
        seed             = 32'h48fc_3d51;
        aclk             = 1'b0;
        aresetn          = 1'b0;
        s_udphdr_tdata   = '0;
        s_udphdr_tvalid  = 1'b0;
        s_udpdata_tdata  = '0;
        s_udpdata_tkeep  = '0;
        s_udpdata_tlast  = 1'b0;
        s_udpdata_tvalid = 1'b0;
        sclk             = 1'b1;
        cs_b             = 1'b1;
        complete_exp     = 1'b0;
        total_errors     = 0;
        tests_run        = 0;
        tests_failed     = 0;
        test_errors      = 0;
        test_name        = "startup";
        repeat (2) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        repeat (4) @(posedge aclk);
        #1;
        assert (s_udphdr_tready === 1'b1)
            else log_mismatch("header tready", 64'(1), 64'(s_udphdr_tready));
        assert (irq_o === 1'b0) else log_mismatch("irq_o", 64'(0), 64'(irq_o));
        assert (complete_o === 1'b0) else log_mismatch("complete_o", 64'(0), 64'(complete_o));
        assert (miso === 1'b0) else log_mismatch("miso", 64'(0), 64'(miso));
        fd = $fopen("hsk_read_stim.txt", "r");
        assert (fd != 0) else flag_error("stimulus file could not be opened");
        close_test();

        while (fd != 0 && !$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) != 0 && line.len() > 0 && line.getc(0) != "#") begin
                if ($sscanf(line, "%s %d %d %d", name, nbytes, admit, reads) == 4) begin
                    test_name   = name;
                    test_errors = 0;
                    send_packet(nbytes, admit != 0);
                    if (admit != 0) begin
                        wait_flag(1'b1, "irq_o");
                    end else begin
                        // a dumped packet leaves irq as the queue had it
                        repeat (8) @(posedge aclk);
                        #1;
                        assert (irq_o === (exp_lengths.size() != 0))
                            else log_mismatch("irq_o after drop",
                                              64'(exp_lengths.size() != 0), 64'(irq_o));
                    end
                    repeat (reads) read_packet();
                    close_test();
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0 && tests_run > 1) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- hsk_read_stim.txt
# columns: test name, payload bytes, expected admit (1) or drop (0),
# and the number of packets read out over the serial port afterwards
single_13b         13  1  1
queued_a           40  1  0
queued_b            5  1  0
queued_c           64  1  3
oversize_drop    4100  0  1
full_a             24  1  0
full_b             17  1  0
full_c              8  1  0
full_d             33  1  0
full_e_dumped      16  0  4
complete_hold       9  1  1

//--- hsk_read_top.f
hsk_stream_pkg.sv
hsk_serial_pkg.sv
hsk_fifo.sv
udp_rx_writer.sv
hsk_serial_reader.sv
hsk_read_top.sv
hsk_read_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= hsk_read_tb
FILELIST  ?= hsk_read_top.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -o $(TOP) -f $(FILELIST)
	@out="$$(./$(BUILD)/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(BUILD)
